/* rtl/sram_pkg.sv */
`default_nettype none

package sram_pkg;

	// bus widths
	localparam int unsigned ADDR_W = 32;
	localparam int unsigned DATA_W = 64;
	localparam int unsigned STRB_W = DATA_W / 8;

	// array geometry
	localparam int unsigned MEM_WORDS = 1024;
	localparam int unsigned WORD_IDX_W = $clog2(MEM_WORDS);
	// low address bits pick a byte inside a word
	localparam int unsigned BYTE_OFS_W = $clog2(STRB_W);

	// address window served by the array
	localparam logic [ADDR_W-1:0] MEM_BASE = 32'h8000_0000;
	localparam logic [ADDR_W-1:0] MEM_BYTES = MEM_WORDS * STRB_W;

	// response codes
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// true when addr falls inside the window
	function automatic logic in_window(input logic [ADDR_W-1:0] addr);
		logic [ADDR_W-1:0] ofs;
		// below base wraps to a huge offset so one compare covers both ends
		ofs = addr - MEM_BASE;
		return ofs < MEM_BYTES;
	endfunction

	// word index inside the array with the byte bits dropped
	function automatic logic [WORD_IDX_W-1:0] word_index(input logic [ADDR_W-1:0] addr);
		logic [ADDR_W-1:0] ofs;
		ofs = addr - MEM_BASE;
		return ofs[BYTE_OFS_W +: WORD_IDX_W];
	endfunction

endpackage

`default_nettype wire

/* rtl/sram_read_port.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_read_port import sram_pkg::*; (
	input  wire logic                  clk,
	input  wire logic                  rst,

	// read address channel
	input  wire logic                  arvalid,
	input  wire logic [ADDR_W-1:0]     araddr,
	output logic                       arready,

	// read data channel
	output logic                       rvalid,
	output logic [DATA_W-1:0]          rdata,
	output logic [1:0]                 rresp,
	input  wire logic                  rready,

	// request to the store
	output logic                       rd_en,
	output logic [WORD_IDX_W-1:0]      rd_idx,
	input  wire logic [DATA_W-1:0]     rd_word
);

	// response waiting for rready
	logic pending;
	// latched window miss of the accepted address
	logic err_q;
	// address handshake this cycle
	logic ar_fire;
	// current address is inside the window
	logic ar_ok;

	// one outstanding read so ready just means nothing pending
	assign arready = ~pending;
	assign ar_fire = arvalid & arready;

	// window check on the live address
	assign ar_ok = in_window(araddr);

	// store lookup on the same edge as the handshake
	// out of window never touches the array
	assign rd_en = ar_fire & ar_ok;
	assign rd_idx = word_index(araddr);

	// pending flag
	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= 1'b0;
		end else if (ar_fire) begin
			pending <= 1'b1;
		end else if (pending & rready) begin
			// response taken
			pending <= 1'b0;
		end
	end

	// error flag only updates on accept so it holds under back-pressure
	always_ff @(posedge clk) begin
		if (ar_fire) begin
			err_q <= ~ar_ok;
		end
	end

	assign rvalid = pending;

	// store output holds between lookups so data stays stable while waiting
	// misses read as zero
	assign rdata = err_q ? '0 : rd_word;
	assign rresp = err_q ? RESP_SLVERR : RESP_OKAY;

endmodule

`default_nettype wire

/* rtl/sram_write_port.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_write_port import sram_pkg::*; (
	input  wire logic                  clk,
	input  wire logic                  rst,

	// write address channel
	input  wire logic                  awvalid,
	input  wire logic [ADDR_W-1:0]     awaddr,
	output logic                       awready,

	// write data channel
	input  wire logic                  wvalid,
	input  wire logic [DATA_W-1:0]     wdata,
	input  wire logic [STRB_W-1:0]     wstrb,
	output logic                       wready,

	// write response channel
	output logic                       bvalid,
	output logic [1:0]                 bresp,
	input  wire logic                  bready,

	// request to the store
	output logic                       wr_en,
	output logic [WORD_IDX_W-1:0]      wr_idx,
	output logic [DATA_W-1:0]          wr_word,
	output logic [STRB_W-1:0]          wr_strb
);

	// response waiting for bready
	logic pending;
	// registered response code
	logic [1:0] bresp_q;
	// address and data taken together
	logic w_fire;
	// current address is inside the window
	logic aw_ok;

	// both channels ready while idle
	assign awready = ~pending;
	assign wready = ~pending;

	// address and data only move as a pair
	// a lone awvalid or wvalid waits
	assign w_fire = awvalid & wvalid & ~pending;

	assign aw_ok = in_window(awaddr);

	// write goes to the array on the accept edge
	assign wr_en = w_fire & aw_ok;
	assign wr_idx = word_index(awaddr);
	// data and strobes go straight through
	assign wr_word = wdata;
	assign wr_strb = wstrb;

	// pending flag
	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= 1'b0;
		end else if (w_fire) begin
			pending <= 1'b1;
		end else if (pending & bready) begin
			pending <= 1'b0;
		end
	end

	// response code captured at accept and held until taken
	always_ff @(posedge clk) begin
		if (w_fire) begin
			bresp_q <= aw_ok ? RESP_OKAY : RESP_SLVERR;
		end
	end

	assign bvalid = pending;
	assign bresp = bresp_q;

endmodule

`default_nettype wire

/* rtl/sram_store.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_store import sram_pkg::*; (
	input  wire logic                  clk,

	// read side
	input  wire logic                  rd_en,
	input  wire logic [WORD_IDX_W-1:0] rd_idx,
	output logic [DATA_W-1:0]          rd_word,

	// byte-masked write side
	input  wire logic                  wr_en,
	input  wire logic [WORD_IDX_W-1:0] wr_idx,
	input  wire logic [DATA_W-1:0]     wr_word,
	input  wire logic [STRB_W-1:0]     wr_strb
);

	// word array with one entry per 64-bit word
	logic [DATA_W-1:0] mem [MEM_WORDS];

	// registered read output
	logic [DATA_W-1:0] rd_q;

	// strobe bit i owns byte lane i
	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int i = 0; i < STRB_W; i++) begin
				if (wr_strb[i]) begin
					mem[wr_idx][i*8 +: 8] <= wr_word[i*8 +: 8];
				end
			end
		end
	end

	// registered read
	// nonblocking update means a same-edge write is not seen yet
	// so a colliding read gets the old word
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_q <= mem[rd_idx];
		end
	end

	// held between lookups
	assign rd_word = rd_q;

endmodule

`default_nettype wire

/* rtl/sram_axi_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_axi_slave import sram_pkg::*; (
	input  wire logic                  clk,
	input  wire logic                  rst,

	// read address
	input  wire logic                  arvalid,
	input  wire logic [ADDR_W-1:0]     araddr,
	output logic                       arready,

	// read data
	output logic                       rvalid,
	output logic [DATA_W-1:0]          rdata,
	output logic [1:0]                 rresp,
	input  wire logic                  rready,

	// write address and data
	input  wire logic                  awvalid,
	input  wire logic [ADDR_W-1:0]     awaddr,
	output logic                       awready,
	input  wire logic                  wvalid,
	input  wire logic [DATA_W-1:0]     wdata,
	input  wire logic [STRB_W-1:0]     wstrb,
	output logic                       wready,

	// write response
	output logic                       bvalid,
	output logic [1:0]                 bresp,
	input  wire logic                  bready
);

	// read port to store
	logic                  rd_en;
	logic [WORD_IDX_W-1:0] rd_idx;
	logic [DATA_W-1:0]     rd_word;

	// write port to store
	logic                  wr_en;
	logic [WORD_IDX_W-1:0] wr_idx;
	logic [DATA_W-1:0]     wr_word;
	logic [STRB_W-1:0]     wr_strb;

	// read channel
	sram_read_port i_sram_read_port (
		.clk     (clk),
		.rst     (rst),
		.arvalid (arvalid),
		.araddr  (araddr),
		.arready (arready),
		.rvalid  (rvalid),
		.rdata   (rdata),
		.rresp   (rresp),
		.rready  (rready),
		.rd_en   (rd_en),
		.rd_idx  (rd_idx),
		.rd_word (rd_word)
	);

	// write channel
	sram_write_port i_sram_write_port (
		.clk     (clk),
		.rst     (rst),
		.awvalid (awvalid),
		.awaddr  (awaddr),
		.awready (awready),
		.wvalid  (wvalid),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wready  (wready),
		.bvalid  (bvalid),
		.bresp   (bresp),
		.bready  (bready),
		.wr_en   (wr_en),
		.wr_idx  (wr_idx),
		.wr_word (wr_word),
		.wr_strb (wr_strb)
	);

	// shared array
	sram_store i_sram_store (
		.clk     (clk),
		.rd_en   (rd_en),
		.rd_idx  (rd_idx),
		.rd_word (rd_word),
		.wr_en   (wr_en),
		.wr_idx  (wr_idx),
		.wr_word (wr_word),
		.wr_strb (wr_strb)
	);

endmodule

`default_nettype wire

/* bench/sram_tests.svh */
	// full words at spread indexes including both ends of the array
	task automatic full_word_rw();
		int idx [5] = '{0, 1, 77, 512, 1023};
		for (int i = 0; i < 5; i++) begin
			do_write(word_addr(idx[i]), {$random(seed), $random(seed)}, 8'hff, 0);
			do_read(word_addr(idx[i]), 0);
		end
	endtask

	// partial writes merge into one word
	task automatic strobe_merge();
		logic [STRB_W-1:0] strbs [6] = '{8'h0f, 8'hf0, 8'h01, 8'h80, 8'h5a, 8'h00};
		logic [ADDR_W-1:0] base;
		base = word_addr(100);
		do_write(base, 64'h0123_4567_89ab_cdef, 8'hff, 0);
		for (int i = 0; i < 6; i++) begin
			do_write(base + 32'(i), {$random(seed), $random(seed)}, strbs[i], 0);
			// byte offset differs from the write, same word expected
			do_read(base + 32'(7 - i), 0);
		end
	endtask

	// misses on both sides then a sweep of everything written so far
	task automatic window_errors();
		logic [ADDR_W-1:0] bad [5];
		int n;
		bad[0] = MEM_BASE - 32'd8;
		bad[1] = MEM_BASE - 32'd1;
		bad[2] = MEM_BASE + MEM_BYTES;
		bad[3] = 32'hffff_fff8;
		bad[4] = 32'h0000_0000;
		for (int i = 0; i < 5; i++) begin
			do_read(bad[i], 0);
			do_write(bad[i], {$random(seed), $random(seed)}, 8'hff, 0);
		end
		n = touched.size();
		for (int i = 0; i < n; i++) begin
			do_read(word_addr(touched[i]), 0);
		end
	endtask

	// awvalid alone then wvalid alone
	// neither may start a write
	task automatic lone_valid_rejected(input logic [ADDR_W-1:0] addr);
		@(posedge clk);
		awvalid <= 1'b1;
		awaddr <= addr;
		wdata <= 64'hbad0_bad0_bad0_bad0;
		wstrb <= 8'hff;
		repeat (3) begin
			@(negedge clk);
			check_equal(64'(bvalid), 64'd0, "no response with awvalid alone");
		end
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid <= 1'b1;
		repeat (3) begin
			@(negedge clk);
			check_equal(64'(bvalid), 64'd0, "no response with wvalid alone");
		end
		@(posedge clk);
		wvalid <= 1'b0;
		@(negedge clk);
		check_equal(64'(bvalid), 64'd0, "no response after lone valids");
		// word must be untouched
		do_read(addr, 0);
	endtask

	// ready held low 1 to 8 cycles
	// stability checked inside the access tasks
	task automatic back_pressure();
		logic [31:0] rnd;
		logic [ADDR_W-1:0] addr;
		addr = word_addr(200);
		for (int i = 0; i < 4; i++) begin
			rnd = $random(seed);
			do_write(addr + 32'(i), {$random(seed), $random(seed)}, 8'hff, int'(rnd[2:0]) + 1);
			do_read(addr, int'(rnd[6:4]) + 1);
		end
		// error responses hold just the same
		do_read(32'h0000_1000, 5);
		do_write(32'h0000_1000, 64'h5555_aaaa_5555_aaaa, 8'hff, 3);
		lone_valid_rejected(addr);
	endtask

	// mixed traffic over a preloaded block
	// about one access in ten misses
	task automatic random_traffic();
		logic [31:0] rnd;
		logic [31:0] pay;
		logic [ADDR_W-1:0] addr;
		int base_word;
		base_word = 600;
		// defined contents first so every in-window read has a known answer
		for (int i = 0; i < 32; i++) begin
			do_write(word_addr(base_word + i), {$random(seed), $random(seed)}, 8'hff, 0);
		end
		for (int n = 0; n < 200; n++) begin
			rnd = $random(seed);
			pay = $random(seed);
			if (rnd[31:24] < 8'd26) begin
				addr = rnd[8] ? MEM_BASE - 32'(rnd[19:12]) - 32'd1
					: MEM_BASE + MEM_BYTES + 32'(rnd[19:12]);
			end else begin
				addr = word_addr(base_word + int'(rnd[4:0])) + 32'(rnd[7:5]);
			end
			if (rnd[9]) begin
				do_write(addr, {$random(seed), $random(seed)}, pay[7:0], int'(pay[10:8]));
			end else begin
				do_read(addr, int'(pay[14:12]));
			end
		end
	endtask

	// read and write accepted on the same edge
	task automatic concurrent_channels();
		do_write(word_addr(300), 64'h1111_2222_3333_4444, 8'hff, 0);
		do_write(word_addr(301), 64'h5555_6666_7777_8888, 8'hff, 0);
		fork
			do_read(word_addr(300), 0);
			do_write(word_addr(301), 64'h9999_aaaa_bbbb_cccc, 8'hff, 0);
		join
		do_read(word_addr(301), 0);
		// same word gives old data first and new data on the next read
		fork
			do_read(word_addr(300), 1);
			do_write(word_addr(300), 64'hdddd_eeee_ffff_0000, 8'hff, 0);
		join
		do_read(word_addr(300), 0);
	endtask

/* bench/sram_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_tb import sram_pkg::*; ();

	// worst operation is well under 40 cycles
	// margin covers reset
	localparam int NUM_OPS = 320;
	localparam int WATCHDOG_CYCLES = NUM_OPS * 40 + 100;

	logic clk;
	logic rst;
	logic arvalid, arready, rvalid, rready;
	logic [ADDR_W-1:0] araddr, awaddr;
	logic [DATA_W-1:0] rdata, wdata;
	logic [1:0] rresp, bresp;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic [STRB_W-1:0] wstrb;

	// byte image of the window as the expected memory
	logic [7:0] ref_mem [MEM_WORDS*8];
	// word indexes written so far
	int touched [$];
	int error_count = 0;
	int check_count = 0;
	integer seed = 32'h36e2_0815;

	sram_axi_slave i_sram_axi_slave (.*);

	// 10 ns clock
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// hang guard
	initial begin
		#(WATCHDOG_CYCLES * 10);
		$display("timeout: run still busy after %0d cycles", WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	// window from base and size in 64 bits so the top end cannot wrap
	function automatic logic addr_in_window(input logic [ADDR_W-1:0] addr);
		return addr >= MEM_BASE && 64'(addr) < 64'(MEM_BASE) + 64'(MEM_WORDS) * 64'd8;
	endfunction

	// byte offset into the window divided down to a word
	function automatic int word_of(input logic [ADDR_W-1:0] addr);
		return int'((addr - MEM_BASE) >> 3);
	endfunction

	function automatic logic [ADDR_W-1:0] word_addr(input int idx);
		return MEM_BASE + 32'(idx) * 32'd8;
	endfunction

	function automatic logic [DATA_W-1:0] ref_word(input int idx);
		logic [DATA_W-1:0] w;
		for (int b = 0; b < 8; b++) begin
			w[b*8 +: 8] = ref_mem[idx*8 + b];
		end
		return w;
	endfunction

	// strobe bit b owns byte lane b
	function automatic void ref_write(input int idx, input logic [DATA_W-1:0] data,
			input logic [STRB_W-1:0] strb);
		for (int b = 0; b < 8; b++) begin
			if (strb[b]) begin
				ref_mem[idx*8 + b] = data[b*8 +: 8];
			end
		end
	endfunction

	task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
			input string msg);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("Fail at %0d ns: %s, got %h, expected %h", $time, msg, actual, expected);
		end
	endtask

	// one write with bready held low for delay cycles after bvalid rises
	task automatic do_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
			input logic [STRB_W-1:0] strb, input int delay);
		logic [1:0] exp_resp;
		logic [1:0] held_resp;
		exp_resp = addr_in_window(addr) ? RESP_OKAY : RESP_SLVERR;
		@(posedge clk);
		awvalid <= 1'b1;
		awaddr <= addr;
		wvalid <= 1'b1;
		wdata <= data;
		wstrb <= strb;
		// transfer at the first edge that sees both readies up
		@(negedge clk);
		while (!(awready && wready)) begin
			@(negedge clk);
		end
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		@(negedge clk);
		if (addr_in_window(addr)) begin
			ref_write(word_of(addr), data, strb);
			touched.push_back(word_of(addr));
		end
		check_equal(64'(bvalid), 64'd1, "bvalid after write transfer");
		held_resp = bresp;
		for (int i = 0; i < delay; i++) begin
			@(negedge clk);
			check_equal(64'(bvalid), 64'd1, "bvalid under back-pressure");
			check_equal(64'(bresp), 64'(held_resp), "bresp stable under back-pressure");
			check_equal(64'(awready | wready), 64'd0, "write readies low while pending");
		end
		@(posedge clk);
		bready <= 1'b1;
		@(negedge clk);
		check_equal(64'(bresp), 64'(exp_resp), $sformatf("bresp for write to %h", addr));
		@(posedge clk);
		bready <= 1'b0;
		@(negedge clk);
		check_equal(64'(bvalid), 64'd0, "bvalid drops after response transfer");
	endtask

	// one read with rready held low for delay cycles after rvalid rises
	task automatic do_read(input logic [ADDR_W-1:0] addr, input int delay);
		logic [DATA_W-1:0] exp_data;
		logic [1:0] exp_resp;
		logic [DATA_W-1:0] held_data;
		logic [1:0] held_resp;
		@(posedge clk);
		arvalid <= 1'b1;
		araddr <= addr;
		@(negedge clk);
		while (!arready) begin
			@(negedge clk);
		end
		// expectation taken just before the transfer edge
		// so a same-edge write is not yet in the model
		exp_data = addr_in_window(addr) ? ref_word(word_of(addr)) : '0;
		exp_resp = addr_in_window(addr) ? RESP_OKAY : RESP_SLVERR;
		@(posedge clk);
		arvalid <= 1'b0;
		@(negedge clk);
		check_equal(64'(rvalid), 64'd1, "rvalid after address transfer");
		held_data = rdata;
		held_resp = rresp;
		for (int i = 0; i < delay; i++) begin
			@(negedge clk);
			check_equal(64'(rvalid), 64'd1, "rvalid under back-pressure");
			check_equal(rdata, held_data, "rdata stable under back-pressure");
			check_equal(64'(rresp), 64'(held_resp), "rresp stable under back-pressure");
			check_equal(64'(arready), 64'd0, "arready low while pending");
		end
		@(posedge clk);
		rready <= 1'b1;
		@(negedge clk);
		check_equal(rdata, exp_data, $sformatf("rdata for read at %h", addr));
		check_equal(64'(rresp), 64'(exp_resp), $sformatf("rresp for read at %h", addr));
		@(posedge clk);
		rready <= 1'b0;
		@(negedge clk);
		check_equal(64'(rvalid), 64'd0, "rvalid drops after response transfer");
	endtask

`include "sram_tests.svh"

	initial begin
		// idle bus and reset held for three edges
		rst <= 1'b1;
		arvalid <= 1'b0;
		araddr <= '0;
		rready <= 1'b0;
		awvalid <= 1'b0;
		awaddr <= '0;
		wvalid <= 1'b0;
		wdata <= '0;
		wstrb <= '0;
		bready <= 1'b0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_equal(64'(rvalid | bvalid), 64'd0, "valids low after reset");
		check_equal(64'(arready & awready & wready), 64'd1, "readies high after reset");
		full_word_rw();
		strobe_merge();
		window_errors();
		back_pressure();
		random_traffic();
		concurrent_channels();
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+bench
rtl/sram_pkg.sv
rtl/sram_read_port.sv
rtl/sram_write_port.sv
rtl/sram_store.sv
rtl/sram_axi_slave.sv
bench/sram_tb.sv

/* run.sh */
#!/bin/sh
# build and run the sram testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --timescale 1ns/1ps -f list.f --top-module sram_tb \
	-Mdir obj_dir -o sram_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sram_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# verdict comes from the log
if grep -q "TEST FAILED" "$log"; then
	echo "failures found in $log"
	exit 1
fi
exit 0
